// ==== sources.f ====
logic/cache_geom_pkg.sv
logic/cache_word_pkg.sv
logic/cache_ifs.sv
logic/fill_ctrl.sv
logic/tag_lookup.sv
logic/data_way_ram.sv
logic/read_merge.sv
logic/cache_top.sv
sim/tb_clk_gen.sv
sim/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f sources.f \
  -o cache_sim > build.log 2>&1 \
  && ./obj_dir/cache_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"

// ==== sim/cache_tb.sv ====
// cache array testbench
`default_nettype none

module cache_tb;
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  localparam int byte_w = data_width / num_lanes;

  typedef logic [addr_width-1:0] addr_t;

  typedef struct packed {
    logic wen;
    addr_t waddr;
    logic [data_width-1:0] wdata;
    lane_vec_t ben;
    lane_vec_t inj;
    addr_t a_addr;
    addr_t b_addr;
    logic a_hit;
    logic [data_width-1:0] a_data;
    logic a_err;
    logic b_hit;
    logic [data_width-1:0] b_data;
    logic b_err;
  } step_t;

  logic clk;
  logic rst;
  logic write_wen;
  addr_t write_addr;
  logic [data_width-1:0] write_data;
  lane_vec_t write_ben;
  lane_vec_t write_par_inject;
  logic read_a_en;
  addr_t read_a_addr;
  logic read_b_en;
  addr_t read_b_addr;
  logic ready;
  logic read_a_hit;
  logic [data_width-1:0] read_a_data;
  logic read_a_err;
  logic read_b_hit;
  logic [data_width-1:0] read_b_data;
  logic read_b_err;

  step_t steps [$];
  int table_len = 0;
  int hit_errs = 0;
  int data_errs = 0;
  int err_errs = 0;
  int ready_errs = 0;

  // reference model with one entry per set and way
  tag_t m_tag [num_sets][num_ways];
  logic m_valid [num_sets][num_ways];
  logic [data_width-1:0] m_data [num_sets][num_ways];
  lane_vec_t m_bad [num_sets][num_ways];     // lanes holding a flipped parity bit
  int m_ptr [num_sets];

  tb_clk_gen #(.period(8), .reset_cycles(10)) u_clk (.clk(clk), .rst(rst));

  cache_top DUT (
    .clk(clk),
    .rst(rst),
    .write_wen(write_wen),
    .write_addr(write_addr),
    .write_data(write_data),
    .write_ben(write_ben),
    .write_par_inject(write_par_inject),
    .read_a_en(read_a_en),
    .read_a_addr(read_a_addr),
    .read_b_en(read_b_en),
    .read_b_addr(read_b_addr),
    .ready(ready),
    .read_a_hit(read_a_hit),
    .read_a_data(read_a_data),
    .read_a_err(read_a_err),
    .read_b_hit(read_b_hit),
    .read_b_data(read_b_data),
    .read_b_err(read_b_err)
  );

  function automatic addr_t addr_of(input tag_t tag, input index_t idx);
    return {tag, idx};
  endfunction

  task automatic push_step(input logic wen, input addr_t waddr, input lane_vec_t ben,
                           input lane_vec_t inj, input addr_t a_addr, input addr_t b_addr);
    step_t s;
    s = '0;
    s.wen = wen;
    s.waddr = waddr;
    s.wdata = $urandom;
    s.ben = ben;
    s.inj = inj;
    s.a_addr = a_addr;
    s.b_addr = b_addr;
    steps.push_back(s);
  endtask

  function automatic int model_find(input addr_t addr);
    for (int w = 0; w < num_ways; w++) begin
      if (m_valid[addr[index_width-1:0]][w] &&
          m_tag[addr[index_width-1:0]][w] == addr[addr_width-1:index_width])
        return w;
    end
    return -1;
  endfunction

  task automatic model_write(input addr_t addr, input logic [data_width-1:0] data,
                             input lane_vec_t ben, input lane_vec_t inj);
    index_t idx;
    int way;
    idx = addr[index_width-1:0];
    way = model_find(addr);
    if (way < 0) begin    // allocate the round-robin victim as a zeroed line
      way = m_ptr[idx];
      m_ptr[idx] = (m_ptr[idx] + 1) % num_ways;
      m_tag[idx][way] = addr[addr_width-1:index_width];
      m_valid[idx][way] = 1'b1;
      m_data[idx][way] = '0;
      m_bad[idx][way] = '0;
    end
    for (int i = 0; i < num_lanes; i++) begin
      if (ben[i]) begin
        m_data[idx][way][i*byte_w +: byte_w] = data[i*byte_w +: byte_w];
        m_bad[idx][way][i] = inj[i];
      end
    end
  endtask

  task automatic model_read(input addr_t addr, output logic hit,
                            output logic [data_width-1:0] data, output logic err);
    int w;
    w = model_find(addr);
    hit = (w >= 0);
    data = '0;
    err = 1'b0;
    if (w >= 0) begin
      data = m_data[addr[index_width-1:0]][w];
      err = |m_bad[addr[index_width-1:0]][w];
    end
  endtask

  task automatic build_table();
    addr_t pool [10];
    // reads straight after the sweep
    push_step(1'b0, '0, '0, '0, addr_of(8'h7f, 5'd31), addr_of(8'h00, 5'd0));
    push_step(1'b0, '0, '0, '0, addr_of(8'h12, 5'd3), addr_of(8'h00, 5'd5));
    push_step(1'b0, '0, '0, '0, addr_of(8'h34, 5'd7), addr_of(8'hff, 5'd20));
    // full writes
    push_step(1'b1, addr_of(8'h12, 5'd3), 4'hf, 4'h0, addr_of(8'h12, 5'd3), addr_of(8'h12, 5'd3));
    push_step(1'b1, addr_of(8'h34, 5'd7), 4'hf, 4'h0, addr_of(8'h34, 5'd7), addr_of(8'h12, 5'd3));
    // partial hit then partial miss
    push_step(1'b1, addr_of(8'h12, 5'd3), 4'b0101, 4'h0, addr_of(8'h12, 5'd3),
              addr_of(8'h34, 5'd7));
    push_step(1'b1, addr_of(8'h56, 5'd9), 4'b0010, 4'h0, addr_of(8'h56, 5'd9),
              addr_of(8'h12, 5'd3));
    // five tags into set 20 evict tag 1
    for (int t = 1; t <= 5; t++)
      push_step(1'b1, addr_of(tag_t'(t), 5'd20), 4'hf, 4'h0, addr_of(tag_t'(t), 5'd20),
                addr_of(8'h01, 5'd20));
    push_step(1'b0, '0, '0, '0, addr_of(8'h01, 5'd20), addr_of(8'h02, 5'd20));
    push_step(1'b0, '0, '0, '0, addr_of(8'h03, 5'd20), addr_of(8'h04, 5'd20));
    push_step(1'b0, '0, '0, '0, addr_of(8'h05, 5'd20), addr_of(8'h02, 5'd20));
    // different sets on the two ports
    push_step(1'b0, '0, '0, '0, addr_of(8'h12, 5'd3), addr_of(8'h56, 5'd9));
    // flipped parity on lane 2 and a clean rewrite after it
    push_step(1'b1, addr_of(8'h34, 5'd7), 4'hf, 4'b0100, addr_of(8'h34, 5'd7),
              addr_of(8'h34, 5'd7));
    push_step(1'b1, addr_of(8'h34, 5'd7), 4'hf, 4'h0, addr_of(8'h34, 5'd7),
              addr_of(8'h12, 5'd3));
    // random traffic over five tags per set so lines get evicted
    for (int i = 0; i < 10; i++)
      pool[i] = addr_of(tag_t'(8'h40 + i), index_t'(10 + i % 2));
    for (int i = 0; i < 12; i++)
      push_step(1'b1, pool[$urandom % 10], lane_vec_t'($urandom),
                ($urandom % 4 == 0) ? lane_vec_t'($urandom) : '0,
                pool[$urandom % 10], pool[$urandom % 10]);
  endtask

  task automatic fill_expected();
    step_t s;
    for (int i = 0; i < num_sets; i++) begin
      m_ptr[i] = 0;
      for (int w = 0; w < num_ways; w++)
        m_valid[i][w] = 1'b0;
    end
    for (int k = 0; k < steps.size(); k++) begin
      s = steps[k];
      if (s.wen)
        model_write(s.waddr, s.wdata, s.ben, s.inj);
      model_read(s.a_addr, s.a_hit, s.a_data, s.a_err);
      model_read(s.b_addr, s.b_hit, s.b_data, s.b_err);
      steps[k] = s;
    end
  endtask

  task automatic check_port(input int k, input string port, input logic hit,
                            input logic exp_hit, input logic [data_width-1:0] data,
                            input logic [data_width-1:0] exp_data, input logic err,
                            input logic exp_err);
    assert (hit === exp_hit) else begin
      hit_errs++;
      $display("mismatch at %0t: step %0d port %s hit %b, expected %b",
               $time, k, port, hit, exp_hit);
    end
    assert (data === exp_data) else begin
      data_errs++;
      $display("mismatch at %0t: step %0d port %s data %h, expected %h",
               $time, k, port, data, exp_data);
    end
    assert (err === exp_err) else begin
      err_errs++;
      $display("mismatch at %0t: step %0d port %s err %b, expected %b",
               $time, k, port, err, exp_err);
    end
  endtask

  // write then two idle cycles and one read on each port
  task automatic run_step(input int k);
    step_t s;
    s = steps[k];
    @(negedge clk);
    write_wen = s.wen;
    write_addr = s.waddr;
    write_data = s.wdata;
    write_ben = s.ben;
    write_par_inject = s.inj;
    @(negedge clk);
    write_wen = 1'b0;
    @(negedge clk);
    read_a_en = 1'b1;
    read_a_addr = s.a_addr;
    read_b_en = 1'b1;
    read_b_addr = s.b_addr;
    @(negedge clk);
    check_port(k, "a", read_a_hit, s.a_hit, read_a_data, s.a_data, read_a_err, s.a_err);
    check_port(k, "b", read_b_hit, s.b_hit, read_b_data, s.b_data, read_b_err, s.b_err);
    read_a_en = 1'b0;
    read_b_en = 1'b0;
  endtask

  initial begin
    int seed_ret;
    int sweep_cycles;
    write_wen = 1'b0;
    write_addr = '0;
    write_data = '0;
    write_ben = '0;
    write_par_inject = '0;
    read_a_en = 1'b0;
    read_a_addr = '0;
    read_b_en = 1'b0;
    read_b_addr = '0;
    seed_ret = $urandom(32'h002da71d);
    build_table();
    fill_expected();
    table_len = steps.size();
    @(negedge rst);
    sweep_cycles = 0;
    while (!ready) begin    // one count per clock of the init sweep
      @(negedge clk);
      sweep_cycles++;
    end
    assert (sweep_cycles == num_sets) else begin
      ready_errs++;
      $display("mismatch at %0t: ready rose after %0d sweep cycles, expected %0d",
               $time, sweep_cycles, num_sets);
    end
    for (int k = 0; k < table_len; k++)
      run_step(k);
    $display("errors: hit %0d, data %0d, err %0d, ready %0d",
             hit_errs, data_errs, err_errs, ready_errs);
    if (hit_errs + data_errs + err_errs + ready_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // covers reset, sweep and every table step
  initial begin
    wait (table_len != 0);
    repeat (table_len * 16 + 200) @(posedge clk);
    $display("watchdog expired before the table finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// testbench clock and reset
`default_nettype none

module tb_clk_gen #(
  parameter int period = 8,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);    // release away from the active edge
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/cache_top.sv ====
// cache data array top
`default_nettype none

module cache_top (
  input  logic clk,
  input  logic rst,
  input  logic write_wen,
  input  logic [cache_geom_pkg::addr_width-1:0] write_addr,
  input  logic [cache_word_pkg::data_width-1:0] write_data,
  input  logic [cache_word_pkg::num_lanes-1:0] write_ben,
  input  logic [cache_word_pkg::num_lanes-1:0] write_par_inject,
  input  logic read_a_en,
  input  logic [cache_geom_pkg::addr_width-1:0] read_a_addr,
  input  logic read_b_en,
  input  logic [cache_geom_pkg::addr_width-1:0] read_b_addr,
  output logic ready,
  output logic read_a_hit,
  output logic [cache_word_pkg::data_width-1:0] read_a_data,
  output logic read_a_err,
  output logic read_b_hit,
  output logic [cache_word_pkg::data_width-1:0] read_b_data,
  output logic read_b_err
);
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  stage_if stage_bus ();
  way_wr_if wr_bus ();
  rd_req_if rd_bus ();

  way_vec_t hit_a;
  way_vec_t hit_b;
  stored_word_u way_data_a [num_ways];
  stored_word_u way_data_b [num_ways];

  assign rd_bus.a_en = read_a_en;
  assign rd_bus.a_index = read_a_addr[index_width-1:0];
  assign rd_bus.a_tag = read_a_addr[addr_width-1:index_width];
  assign rd_bus.b_en = read_b_en;
  assign rd_bus.b_index = read_b_addr[index_width-1:0];
  assign rd_bus.b_tag = read_b_addr[addr_width-1:index_width];

  fill_ctrl u_fill (
    .clk(clk),
    .rst(rst),
    .write_wen(write_wen),
    .write_addr(write_addr),
    .write_data(write_data),
    .write_ben(write_ben),
    .write_par_inject(write_par_inject),
    .ready(ready),
    .stage(stage_bus)
  );

  tag_lookup u_tags (
    .clk(clk),
    .rst(rst),
    .stage(stage_bus),
    .rd(rd_bus),
    .wr(wr_bus),
    .hit_a(hit_a),
    .hit_b(hit_b)
  );

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    data_way_ram #(.way(w)) u_ram (
      .clk(clk),
      .rst(rst),
      .rd(rd_bus),
      .wr(wr_bus),
      .data_a(way_data_a[w]),
      .data_b(way_data_b[w])
    );
  end

  read_merge u_merge (
    .hit_a(hit_a),
    .hit_b(hit_b),
    .way_data_a(way_data_a),
    .way_data_b(way_data_b),
    .read_a_data(read_a_data),
    .read_b_data(read_b_data),
    .read_a_err(read_a_err),
    .read_b_err(read_b_err)
  );

  assign read_a_hit = |hit_a;
  assign read_b_hit = |hit_b;

endmodule

`default_nettype wire

// ==== logic/read_merge.sv ====
// read merge and parity check
`default_nettype none

module read_merge (
  input  cache_geom_pkg::way_vec_t hit_a,
  input  cache_geom_pkg::way_vec_t hit_b,
  input  cache_word_pkg::stored_word_u way_data_a [cache_geom_pkg::num_ways],
  input  cache_word_pkg::stored_word_u way_data_b [cache_geom_pkg::num_ways],
  output logic [cache_word_pkg::data_width-1:0] read_a_data,
  output logic [cache_word_pkg::data_width-1:0] read_b_data,
  output logic read_a_err,
  output logic read_b_err
);
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  localparam int byte_width = data_width / num_lanes;

  stored_word_u merged_a;
  stored_word_u merged_b;

  // or of the hitting ways, zero on a miss
  function automatic stored_word_u merge_ways(input way_vec_t hit,
                                              input stored_word_u words [num_ways]);
    stored_word_u acc;
    acc = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit[w])
        acc.flat = acc.flat | words[w].flat;
    end
    return acc;
  endfunction

  function automatic logic [data_width-1:0] strip_par(input stored_word_u word);
    logic [data_width-1:0] d;
    for (int i = 0; i < num_lanes; i++)
      d[i*byte_width +: byte_width] = word.lanes[i].data;
    return d;
  endfunction

  function automatic logic lane_err(input stored_word_u word);
    lane_vec_t odd;
    for (int i = 0; i < num_lanes; i++)
      odd[i] = ^word.lanes[i];    // even parity expected
    return |odd;
  endfunction

  assign merged_a = merge_ways(hit_a, way_data_a);
  assign merged_b = merge_ways(hit_b, way_data_b);

  assign read_a_data = strip_par(merged_a);
  assign read_b_data = strip_par(merged_b);
  assign read_a_err = lane_err(merged_a);
  assign read_b_err = lane_err(merged_b);

endmodule

`default_nettype wire

// ==== logic/data_way_ram.sv ====
// data memory of one way
`default_nettype none

module data_way_ram #(
  parameter int way = 0
) (
  input  logic clk,
  input  logic rst,
  rd_req_if.lookup rd,
  way_wr_if.sink wr,
  output cache_word_pkg::stored_word_u data_a,
  output cache_word_pkg::stored_word_u data_b
);
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  logic [num_lanes*lane_width-1:0] mem [num_sets];

  index_t a_addr_q;
  index_t b_addr_q;

  // async read through registered addresses
  assign data_a.flat = mem[a_addr_q];
  assign data_b.flat = mem[b_addr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      a_addr_q <= '0;
      b_addr_q <= '0;
    end else begin
      if (rd.a_en)
        a_addr_q <= rd.a_index;
      if (rd.b_en)
        b_addr_q <= rd.b_index;
    end
  end

  // lane masked write
  always_ff @(posedge clk) begin
    if (wr.way_wen[way]) begin
      for (int i = 0; i < num_lanes; i++) begin
        if (wr.lane_en[i])
          mem[wr.index][i*lane_width +: lane_width] <= wr.word.flat[i*lane_width +: lane_width];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/tag_lookup.sv ====
// tag lookup and way allocation
`default_nettype none

module tag_lookup (
  input  logic clk,
  input  logic rst,
  stage_if.sink stage,
  rd_req_if.lookup rd,
  way_wr_if.source wr,
  output cache_geom_pkg::way_vec_t hit_a,
  output cache_geom_pkg::way_vec_t hit_b
);
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  tag_t tag_mem [num_sets][num_ways];
  way_vec_t valid_mem [num_sets];
  logic [$clog2(num_ways)-1:0] fill_ptr [num_sets];  // round-robin victim

  index_t a_index_q;
  tag_t a_tag_q;
  index_t b_index_q;
  tag_t b_tag_q;

  way_vec_t st_hit;
  way_vec_t victim_vec;
  logic [$clog2(num_ways)-1:0] victim;
  logic alloc;
  stored_word_u wr_word;
  lane_vec_t wr_lanes;

  always_ff @(posedge clk) begin
    if (rst) begin
      a_index_q <= '0;
      a_tag_q <= '0;
      b_index_q <= '0;
      b_tag_q <= '0;
    end else begin
      if (rd.a_en) begin
        a_index_q <= rd.a_index;
        a_tag_q <= rd.a_tag;
      end
      if (rd.b_en) begin
        b_index_q <= rd.b_index;
        b_tag_q <= rd.b_tag;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_a[w] = valid_mem[a_index_q][w] && (tag_mem[a_index_q][w] == a_tag_q);
      hit_b[w] = valid_mem[b_index_q][w] && (tag_mem[b_index_q][w] == b_tag_q);
      st_hit[w] = valid_mem[stage.index][w] && (tag_mem[stage.index][w] == stage.tag)
                  && !stage.init;
    end
  end

  assign victim = fill_ptr[stage.index];
  assign victim_vec = way_vec_t'(1) << victim;
  assign alloc = stage.valid && !stage.init && !(|st_hit);

  // a fresh line gets every lane, disabled bytes forced to zero
  always_comb begin
    wr_word = stage.word;
    wr_lanes = stage.lane_en;
    if (alloc) begin
      for (int i = 0; i < num_lanes; i++) begin
        if (!stage.lane_en[i])
          wr_word.lanes[i] = '0;
      end
      wr_lanes = '1;
    end
  end

  assign wr.way_wen = !stage.valid ? '0 :
                      stage.init   ? '1 :
                      (|st_hit)    ? st_hit : victim_vec;
  assign wr.index = stage.index;
  assign wr.word = wr_word;
  assign wr.lane_en = wr_lanes;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_mem[s] <= '0;
        fill_ptr[s] <= '0;
      end
    end else if (alloc) begin
      valid_mem[stage.index][victim] <= 1'b1;
      fill_ptr[stage.index] <= victim + 1'b1;   // wraps mod 4
    end
  end

  always_ff @(posedge clk) begin
    if (alloc)
      tag_mem[stage.index][victim] <= stage.tag;
  end

endmodule

`default_nettype wire

// ==== logic/fill_ctrl.sv ====
// fill controller
`default_nettype none

module fill_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic write_wen,
  input  logic [cache_geom_pkg::addr_width-1:0] write_addr,
  input  logic [cache_word_pkg::data_width-1:0] write_data,
  input  cache_word_pkg::lane_vec_t write_ben,
  input  cache_word_pkg::lane_vec_t write_par_inject,
  output logic ready,
  stage_if.source stage
);
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  localparam int byte_width = data_width / num_lanes;

  logic sweeping;
  index_t init_cnt;
  index_t wr_index;
  tag_t wr_tag;
  stored_word_u wr_word;

  assign wr_index = write_addr[index_width-1:0];
  assign wr_tag = write_addr[addr_width-1:index_width];

  assign ready = ~sweeping;

  // even parity per byte, optionally flipped for error injection
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      wr_word.lanes[i].data = write_data[i*byte_width +: byte_width];
      wr_word.lanes[i].par = (^write_data[i*byte_width +: byte_width]) ^ write_par_inject[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sweeping <= 1'b1;
      init_cnt <= '0;
      stage.valid <= 1'b0;
      stage.init <= 1'b0;
    end else begin
      stage.valid <= sweeping | write_wen;   // writes dropped while sweeping
      stage.init <= sweeping;
      if (sweeping) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == index_t'(num_sets - 1))
          sweeping <= 1'b0;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (sweeping) begin
      stage.index <= init_cnt;
      stage.word <= '0;
      stage.lane_en <= '1;
    end else begin
      stage.index <= wr_index;
      stage.word <= wr_word;
      stage.lane_en <= write_ben;
    end
    stage.tag <= wr_tag;
  end

endmodule

`default_nettype wire

// ==== logic/cache_ifs.sv ====
// internal cache interfaces
`default_nettype none

// staged request, fill controller to tag lookup
interface stage_if;
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  logic valid;                                // one-cycle strobe
  logic init;                                 // zero all ways at index
  index_t index;
  tag_t tag;
  stored_word_u word;
  lane_vec_t lane_en;

  modport source (output valid, init, index, tag, word, lane_en);
  modport sink (input valid, init, index, tag, word, lane_en);
endinterface

// committed write into the data ways
interface way_wr_if;
  import cache_geom_pkg::*;
  import cache_word_pkg::*;

  way_vec_t way_wen;
  index_t index;
  stored_word_u word;
  lane_vec_t lane_en;

  modport source (output way_wen, index, word, lane_en);
  modport sink (input way_wen, index, word, lane_en);
endinterface

// both read requests as taken from the top ports
interface rd_req_if;
  import cache_geom_pkg::*;

  logic a_en;
  index_t a_index;
  tag_t a_tag;
  logic b_en;
  index_t b_index;
  tag_t b_tag;

  modport lookup (input a_en, a_index, a_tag, b_en, b_index, b_tag);
endinterface

`default_nettype wire

// ==== logic/cache_word_pkg.sv ====
// stored word format
`default_nettype none

package cache_word_pkg;

  localparam int num_lanes = 4;
  localparam int lane_width = 9;              // byte plus parity
  localparam int data_width = 32;

  // even parity bit above its byte
  typedef struct packed {
    logic par;
    logic [lane_width-2:0] data;
  } lane_t;

  // same 36 bits seen flat by the ram, per lane by parity logic
  typedef union packed {
    logic [num_lanes*lane_width-1:0] flat;
    lane_t [num_lanes-1:0] lanes;
  } stored_word_u;

  typedef logic [num_lanes-1:0] lane_vec_t;

endpackage

`default_nettype wire

// ==== logic/cache_geom_pkg.sv ====
// cache geometry constants
`default_nettype none

package cache_geom_pkg;

  localparam int num_ways = 4;
  localparam int num_sets = 32;

  localparam int index_width = 5;
  localparam int tag_width = 8;

  // tag sits above the set index
  localparam int addr_width = tag_width + index_width;

  typedef logic [num_ways-1:0] way_vec_t;     // one bit per way
  typedef logic [index_width-1:0] index_t;
  typedef logic [tag_width-1:0] tag_t;

endpackage

`default_nettype wire
